//--- all.f
+incdir+.
wl_data_pkg.sv
wl_ctrl_pkg.sv
tile_if.sv
kernel_fetcher.sv
column_lane.sv
group_sequencer.sv
weight_loader.sv
weight_loader_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f all.f \
    --top-module weight_loader_tb -o weight_loader_sim

status=0
out=$(./obj_dir/weight_loader_sim 2>&1) || status=$?
printf '%s\n' "$out"
echo "simulator exit status: $status"

# Pass only if the testbench printed its pass line
printf '%s\n' "$out" | grep -qx "Simulation passed"

//--- weight_loader_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "wl_consts.svh"

module weight_loader_tb;
    import wl_data_pkg::*;
    import wl_ctrl_pkg::*;

    localparam int N_TESTS   = 6;
    localparam int TIMEOUT   = 3000;    // Cycles allowed from start to done
    localparam int STALL_PCT = 30;      // Stall probability in stalled rows
    localparam int PERIOD    = `WL_ON_CYCLES + `WL_GAP_CYCLES;
    localparam int N_POS     = `WL_KERNEL * `WL_KERNEL;

    typedef struct {
        string     name;
        logic      single_ch;
        group_t    ch_groups;
        out_ch_t   out_ch;
        rom_addr_t base_addr;
        logic      stall_en;        // Random stall during the run
    } test_row_t;

    logic        clk;
    logic        reset;
    logic        start;
    logic        stall;
    logic        single_ch;
    group_t      ch_groups;
    out_ch_t     out_ch;
    rom_addr_t   base_addr;
    rom_word_u   rom_data_0;
    rom_word_u   rom_data_1;
    rom_word_u   rom_data_2;
    rom_word_u   rom_data_3;
    logic        rom_rd_en;
    rom_addr_t   rom_addr;
    weight_vec_t col_weights [`WL_KERNEL];
    logic        idle;
    logic        done;

    test_row_t   tests [N_TESTS];
    rom_addr_t   rom_q = '0;                // Address latched by the ROM model
    rom_word_u   rom_words [`WL_KERNEL];
    rom_addr_t   got_addr [$];              // Every address read
    weight_vec_t got_vec [`WL_KERNEL][$];   // Nonzero vectors per lane
    int          got_t [`WL_KERNEL][$];     // Unstalled cycle of each vector
    int          run_cycle;
    string       cur_name;

    weight_loader i_weight_loader (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .stall       (stall),
        .single_ch   (single_ch),
        .ch_groups   (ch_groups),
        .out_ch      (out_ch),
        .base_addr   (base_addr),
        .rom_data_0  (rom_data_0),
        .rom_data_1  (rom_data_1),
        .rom_data_2  (rom_data_2),
        .rom_data_3  (rom_data_3),
        .rom_rd_en   (rom_rd_en),
        .rom_addr    (rom_addr),
        .col_weights (col_weights),
        .idle        (idle),
        .done        (done)
    );

    always #4 clk = ~clk;   // 8 ns period

    // Byte c of word k at address a is never zero
    function automatic weight_t rom_byte(input rom_addr_t a, input int k, input int c);
        int v;
        v = (int'(a) * 37 + int'(a) / 251 + k * 11 + c * 5) % 255;
        return weight_t'(v + 1);
    endfunction

    // ROM with one cycle of latency
    always @(posedge clk) begin
        if (reset) begin
            rom_q <= '0;
        end else if (rom_rd_en) begin
            rom_q <= rom_addr;
        end
    end

    always_comb begin
        for (int k = 0; k < `WL_KERNEL; k++) begin
            for (int c = 0; c < `WL_VEC; c++) begin
                rom_words[k].by_ch[c] = rom_byte(rom_q, k, c);
            end
        end
    end

    assign rom_data_0 = rom_words[0];
    assign rom_data_1 = rom_words[1];
    assign rom_data_2 = rom_words[2];
    assign rom_data_3 = rom_words[3];

    // Address rule with one read per row or a single read in single-channel mode
    function automatic rom_addr_t read_addr(input test_row_t t, input int g, input int r);
        int a;
        if (t.single_ch) begin
            a = int'(t.base_addr) + int'(t.out_ch) * `WL_KERNEL;
        end else begin
            a = int'(t.base_addr) + int'(t.out_ch) * `WL_KERNEL * int'(t.ch_groups)
              + g * `WL_KERNEL + r;
        end
        return rom_addr_t'(a);  // Wraps in the 14-bit ROM space
    endfunction

    function automatic weight_vec_t expected_vec(input test_row_t t, input int g, input int p);
        weight_vec_t v;
        rom_addr_t   a;
        v = '0;
        a = read_addr(t, g, p / `WL_KERNEL);
        if (t.single_ch) begin
            v[0] = rom_byte(a, p / `WL_KERNEL, p % `WL_KERNEL);    // Word is the row and byte the column
        end else begin
            for (int c = 0; c < `WL_VEC; c++) begin
                v[c] = rom_byte(a, p % `WL_KERNEL, c);     // Word is the column and byte the channel
            end
        end
        return v;
    endfunction

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("%s", msg);
        stop_run();
    endtask

    task automatic check_weights(input string what, input weight_vec_t exp, input weight_vec_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected %h, actual %h", what, exp, act);
            stop_run();
        end
    endtask

    task automatic check_addr(input string what, input rom_addr_t exp, input rom_addr_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected %h, actual %h", what, exp, act);
            stop_run();
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s: expected %b, actual %b", what, exp, act);
            stop_run();
        end
    endtask

    // Drive on the falling edge and record what the next rising edge takes
    task automatic step(input logic want_start, input logic stall_en);
        @(negedge clk);
        start = want_start;
        stall = stall_en && !want_start && (($urandom % 100) < STALL_PCT);
        #1;     // rom_rd_en follows stall combinationally
        if (stall) begin
            check_flag({cur_name, " rom_rd_en under stall"}, 1'b0, rom_rd_en);
        end else begin
            if (rom_rd_en) begin
                got_addr.push_back(rom_addr);
            end
            for (int i = 0; i < `WL_KERNEL; i++) begin
                if (col_weights[i] != '0) begin
                    got_vec[i].push_back(col_weights[i]);
                    got_t[i].push_back(run_cycle);
                end
            end
            run_cycle++;    // Counts unstalled cycles only
        end
    endtask

    task automatic run_test(input test_row_t t);
        int waited;
        int n_reads;
        int idx;
        int exp_t;
        cur_name = t.name;
        got_addr.delete();
        for (int i = 0; i < `WL_KERNEL; i++) begin
            got_vec[i].delete();
            got_t[i].delete();
        end
        run_cycle = 0;
        @(negedge clk);
        stall     = 1'b0;
        single_ch = t.single_ch;
        ch_groups = t.ch_groups;
        out_ch    = t.out_ch;
        base_addr = t.base_addr;
        step(1'b1, t.stall_en);
        step(1'b0, t.stall_en);
        check_flag({t.name, " idle after start"}, 1'b0, idle);
        check_flag({t.name, " done after start"}, 1'b0, done);
        waited = 0;
        while (done !== 1'b1) begin
            if (waited >= TIMEOUT) begin
                report_error($sformatf("%s: done did not rise within %0d cycles",
                                       t.name, TIMEOUT));
            end
            step(1'b0, t.stall_en);
            waited++;
        end
        check_flag({t.name, " idle at done"}, 1'b1, idle);

        n_reads = t.single_ch ? 1 : `WL_KERNEL * int'(t.ch_groups);
        if (got_addr.size() != n_reads) begin
            report_error($sformatf("FAILED %s ROM read count: expected %0d, actual %0d",
                                   t.name, n_reads, got_addr.size()));
        end
        for (int j = 0; j < n_reads; j++) begin
            check_addr($sformatf("%s read %0d", t.name, j),
                       read_addr(t, j / `WL_KERNEL, j % `WL_KERNEL), got_addr[j]);
        end

        // All groups must be out before done
        for (int i = 0; i < `WL_KERNEL; i++) begin
            if (got_vec[i].size() != N_POS * int'(t.ch_groups)) begin
                report_error($sformatf(
                    "FAILED %s lane %0d vector count: expected %0d, actual %0d",
                    t.name, i, N_POS * int'(t.ch_groups), got_vec[i].size()));
            end
        end
        for (int g = 0; g < int'(t.ch_groups); g++) begin
            for (int i = 0; i < `WL_KERNEL; i++) begin
                for (int p = 0; p < N_POS; p++) begin
                    idx = g * N_POS + p;
                    check_weights($sformatf("%s lane %0d group %0d pos %0d", t.name, i, g, p),
                                  expected_vec(t, g, p), got_vec[i][idx]);
                    // Skew of i and then bursts of four with three zeros between
                    exp_t = got_t[0][g * N_POS] + i + (p / `WL_ON_CYCLES) * PERIOD
                          + p % `WL_ON_CYCLES;
                    if (got_t[i][idx] != exp_t) begin
                        report_error($sformatf(
                            "FAILED %s lane %0d group %0d pos %0d cycle: expected %0d, actual %0d",
                            t.name, i, g, p, exp_t, got_t[i][idx]));
                    end
                end
            end
        end
    endtask

    initial begin
        void'($urandom(70));
        tests[0] = '{"reg_one_group",     1'b0, 7'd1, 6'd0,  14'h0100, 1'b0};
        tests[1] = '{"reg_four_groups",   1'b0, 7'd4, 6'd3,  14'h0200, 1'b0};
        tests[2] = '{"single_ch",         1'b1, 7'd1, 6'd5,  14'h1000, 1'b0};
        tests[3] = '{"reg_wrap_stalled",  1'b0, 7'd3, 6'd7,  14'h3ff0, 1'b1};
        tests[4] = '{"single_ch_stalled", 1'b1, 7'd1, 6'd63, 14'h2000, 1'b1};
        tests[5] = '{"reg_two_stalled",   1'b0, 7'd2, 6'd10, 14'h0040, 1'b1};

        clk       = 1'b0;
        reset     = 1'b1;
        start     = 1'b0;
        stall     = 1'b0;
        single_ch = 1'b0;
        ch_groups = 7'd1;
        out_ch    = '0;
        base_addr = '0;
        repeat (5) @(negedge clk);  // Five rising edges in reset
        reset = 1'b0;
        #1;

        check_flag("after_reset idle", 1'b1, idle);
        check_flag("after_reset done", 1'b0, done);
        check_flag("after_reset rom_rd_en", 1'b0, rom_rd_en);
        for (int i = 0; i < `WL_KERNEL; i++) begin
            check_weights($sformatf("after_reset lane %0d", i), '0, col_weights[i]);
        end

        // Every row after the first starts from done
        for (int n = 0; n < N_TESTS; n++) begin
            run_test(tests[n]);
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- weight_loader.sv
`timescale 1ns/1ps
`default_nettype none

`include "wl_consts.svh"

module weight_loader (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  logic                     stall,         // Global freeze
    input  logic                     single_ch,     // First layer, one input channel
    input  wl_ctrl_pkg::group_t      ch_groups,
    input  wl_ctrl_pkg::out_ch_t     out_ch,
    input  wl_ctrl_pkg::rom_addr_t   base_addr,
    input  wl_data_pkg::rom_word_u   rom_data_0,
    input  wl_data_pkg::rom_word_u   rom_data_1,
    input  wl_data_pkg::rom_word_u   rom_data_2,
    input  wl_data_pkg::rom_word_u   rom_data_3,
    output logic                     rom_rd_en,
    output wl_ctrl_pkg::rom_addr_t   rom_addr,
    output wl_data_pkg::weight_vec_t col_weights [`WL_KERNEL],
    output logic                     idle,
    output logic                     done
);
    import wl_data_pkg::*;

    rom_word_u             rom_words [`WL_KERNEL];  // ROM ports as an array
    logic [`WL_KERNEL-1:0] lane_done;

    assign rom_words[0] = rom_data_0;
    assign rom_words[1] = rom_data_1;
    assign rom_words[2] = rom_data_2;
    assign rom_words[3] = rom_data_3;

    tile_if tile ();

    kernel_fetcher i_kernel_fetcher (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .single_ch (single_ch),
        .out_ch    (out_ch),
        .ch_groups (ch_groups),
        .base_addr (base_addr),
        .rom_data  (rom_words),
        .rom_rd_en (rom_rd_en),
        .rom_addr  (rom_addr),
        .tile      (tile.fetch)
    );

    // Column i starts i cycles after column 0
    for (genvar i = 0; i < `WL_KERNEL; i++) begin : g_lane
        column_lane #(
            .LANE_SKEW (i)
        ) i_column_lane (
            .clk       (clk),
            .reset     (reset),
            .stall     (stall),
            .tile      (tile.lane),
            .weights   (col_weights[i]),
            .lane_done (lane_done[i])
        );
    end

    group_sequencer i_group_sequencer (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .start     (start),
        .ch_groups (ch_groups),
        .lane_done (lane_done),
        .tile      (tile.seq),
        .idle      (idle),
        .done      (done)
    );

endmodule

`default_nettype wire

//--- group_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "wl_consts.svh"

module group_sequencer (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  start,
    input  wl_ctrl_pkg::group_t   ch_groups,     // Number of 4-channel groups
    input  logic [`WL_KERNEL-1:0] lane_done,     // One bit per column lane
    tile_if.seq                   tile,
    output logic                  idle,
    output logic                  done
);
    import wl_ctrl_pkg::*;

    seq_state_t state;
    group_t     group_q;        // Group in flight
    logic       fetch_q;        // Registered fetch request
    logic       last_group;
    logic       all_done;

    assign last_group = (group_q == ch_groups - group_t'(1));

    // Lanes still report done during the fetch_req cycle itself
    assign all_done = (&lane_done) && !fetch_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= SEQ_IDLE;
            group_q <= '0;
            fetch_q <= 1'b0;
        end else if (!stall) begin
            fetch_q <= 1'b0;                    // Pulse by default
            case (state)
                SEQ_IDLE, SEQ_DONE: begin
                    if (start) begin
                        state   <= SEQ_RUN;
                        group_q <= '0;
                        fetch_q <= 1'b1;        // Load group 0
                    end
                end
                SEQ_RUN: begin
                    if (all_done) begin
                        if (last_group) begin
                            state <= SEQ_DONE;
                        end else begin
                            group_q <= group_q + group_t'(1);
                            fetch_q <= 1'b1;    // Load next group
                        end
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    assign tile.fetch_req = fetch_q;
    assign tile.group     = group_q;

    // Status straight from state
    assign idle = (state != SEQ_RUN);
    assign done = (state == SEQ_DONE);

endmodule

`default_nettype wire

//--- column_lane.sv
`timescale 1ns/1ps
`default_nettype none

`include "wl_consts.svh"

module column_lane #(
    parameter int LANE_SKEW = 0                 // Extra delay of this column in cycles
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     stall,
    tile_if.lane                     tile,
    output wl_data_pkg::weight_vec_t weights,   // To one systolic array column
    output logic                     lane_done
);
    import wl_ctrl_pkg::*;

    localparam int SKEW_BITS = (LANE_SKEW > 0) ? $clog2(LANE_SKEW + 1) : 1;

    lane_state_t          state;
    logic [SKEW_BITS-1:0] skew_cnt;     // Cycles spent in skew
    logic [2:0]           phase_cnt;    // Cycle within burst or gap
    pos_t                 pos;          // Next kernel position to send

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= L_IDLE;
            skew_cnt  <= '0;
            phase_cnt <= '0;
            pos       <= '0;
        end else if (!stall) begin
            case (state)
                L_IDLE: begin
                    if (tile.tile_ready) begin
                        state    <= L_SKEW;
                        skew_cnt <= '0;
                    end
                end
                L_SKEW: begin
                    // LANE_SKEW + 1 cycles here
                    if (skew_cnt == SKEW_BITS'(LANE_SKEW)) begin
                        state     <= L_BURST;
                        phase_cnt <= '0;
                        pos       <= '0;
                    end else begin
                        skew_cnt <= skew_cnt + 1'b1;
                    end
                end
                L_BURST: begin
                    pos <= pos + pos_t'(1);     // Wraps to 0 after the last position
                    if (phase_cnt == 3'(`WL_ON_CYCLES - 1)) begin
                        state     <= L_GAP;
                        phase_cnt <= '0;
                    end else begin
                        phase_cnt <= phase_cnt + 3'd1;
                    end
                end
                L_GAP: begin
                    if (phase_cnt == 3'(`WL_GAP_CYCLES - 1)) begin
                        phase_cnt <= '0;
                        // Position back at 0 means all four bursts went out
                        state <= (pos == '0) ? L_DONE : L_BURST;
                    end else begin
                        phase_cnt <= phase_cnt + 3'd1;
                    end
                end
                L_DONE: begin
                    if (tile.fetch_req) begin
                        state <= L_IDLE;        // Next group on its way
                    end
                end
                default: state <= L_IDLE;
            endcase
        end
    end

    // Zero outside bursts
    assign weights   = (state == L_BURST) ? tile.kernel[pos] : '0;
    assign lane_done = (state == L_DONE);   // Held until next fetch_req

endmodule

`default_nettype wire

//--- kernel_fetcher.sv
`timescale 1ns/1ps
`default_nettype none

`include "wl_consts.svh"

module kernel_fetcher (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall,
    input  logic                   single_ch,                // First-layer packing
    input  wl_ctrl_pkg::out_ch_t   out_ch,
    input  wl_ctrl_pkg::group_t    ch_groups,
    input  wl_ctrl_pkg::rom_addr_t base_addr,
    input  wl_data_pkg::rom_word_u rom_data [`WL_KERNEL],    // Word k valid one cycle after read
    output logic                   rom_rd_en,
    output wl_ctrl_pkg::rom_addr_t rom_addr,
    tile_if.fetch                  tile
);
    import wl_data_pkg::*;
    import wl_ctrl_pkg::*;

    logic      busy;            // Reads still to issue
    row_t      rd_row;          // Row being addressed
    row_t      wr_row;          // Row being written
    logic      rd_valid;        // ROM data present this cycle
    logic      rd_last;
    logic      wr_last;
    logic      tile_ready_q;
    rom_addr_t filt_base;       // Start of this output filter
    kernel_t   sc_kernel;       // Single-channel decode of all four words

    // Filter stride is 4 rows per group, ch_groups is 1 in single-channel mode
    assign filt_base = base_addr
                     + rom_addr_t'(out_ch) * rom_addr_t'(ch_groups) * rom_addr_t'(`WL_KERNEL);

    // Group and row are both zero for the one single-channel read
    assign rom_addr = filt_base
                    + rom_addr_t'(tile.group) * rom_addr_t'(`WL_KERNEL)
                    + rom_addr_t'(rd_row);

    assign rom_rd_en = busy && !stall;      // Never read while stalled
    assign rd_last   = single_ch || (rd_row == row_t'(`WL_KERNEL - 1));
    assign wr_last   = rd_valid && (single_ch || (wr_row == row_t'(`WL_KERNEL - 1)));

    // Read side
    always_ff @(posedge clk) begin
        if (reset) begin
            busy   <= 1'b0;
            rd_row <= '0;
        end else if (!stall) begin
            if (tile.fetch_req) begin
                busy   <= 1'b1;             // First read next cycle
                rd_row <= '0;
            end else if (rom_rd_en) begin
                rd_row <= rd_row + row_t'(1);
                if (rd_last) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // Write side keeps running under stall so in-flight data lands
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid     <= 1'b0;
            wr_row       <= '0;
            tile_ready_q <= 1'b0;
        end else begin
            rd_valid <= rom_rd_en;          // One-cycle ROM latency
            if (tile.fetch_req && !stall) begin
                wr_row <= '0;
            end else if (rd_valid) begin
                wr_row <= wr_row + row_t'(1);
            end
            if (wr_last) begin
                tile_ready_q <= 1'b1;       // Buffer full from next cycle
            end else if (!stall) begin
                tile_ready_q <= 1'b0;       // Held until an unstalled cycle sees it
            end
        end
    end

    assign tile.tile_ready = tile_ready_q;

    // Word r is kernel row r, byte q is column q, channels 1 to 3 zero
    always_comb begin
        sc_kernel = '0;
        for (int r = 0; r < `WL_KERNEL; r++) begin
            for (int q = 0; q < `WL_KERNEL; q++) begin
                sc_kernel[r * `WL_KERNEL + q][0] = rom_data[r].by_col[q];
            end
        end
    end

    // Tile buffer
    always_ff @(posedge clk) begin
        if (rd_valid) begin
            if (single_ch) begin
                tile.kernel <= sc_kernel;   // Whole kernel in one read
            end else begin
                // Word k is column k of the current row, all four channels
                for (int k = 0; k < `WL_KERNEL; k++) begin
                    tile.kernel[pos_t'(wr_row * `WL_KERNEL + k)] <= rom_data[k].by_ch;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tile_if.sv
`timescale 1ns/1ps
`default_nettype none

// Fetch request and buffered kernel shared by sequencer, fetcher and lanes
interface tile_if;
    import wl_data_pkg::*;
    import wl_ctrl_pkg::*;

    logic    fetch_req;     // One-cycle pulse, held only while stalled
    group_t  group;         // Channel group to load
    logic    tile_ready;    // Pulse once the buffer is full
    kernel_t kernel;        // Stable until the next fetch_req

    // Sequencer side
    modport seq (
        output fetch_req,
        output group
    );

    // Fetcher side, owns the buffer
    modport fetch (
        input  fetch_req,
        input  group,
        output tile_ready,
        output kernel
    );

    // Column lanes only read
    modport lane (
        input fetch_req,
        input tile_ready,
        input kernel
    );

endinterface

`default_nettype wire

//--- wl_ctrl_pkg.sv
`default_nettype none

`include "wl_consts.svh"

package wl_ctrl_pkg;

    typedef logic [`WL_ADDR_BITS-1:0]   rom_addr_t;   // Weight ROM address
    typedef logic [`WL_GROUP_BITS-1:0]  group_t;      // Channel group index or count
    typedef logic [`WL_OUT_CH_BITS-1:0] out_ch_t;     // Output channel index

    typedef logic [$clog2(`WL_KERNEL)-1:0]            row_t;  // Kernel row
    typedef logic [$clog2(`WL_KERNEL*`WL_KERNEL)-1:0] pos_t;  // Row-major kernel position

    // Group sequencer states
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_RUN,
        SEQ_DONE
    } seq_state_t;

    // Column lane states
    typedef enum logic [2:0] {
        L_IDLE,
        L_SKEW,     // Per-column delay
        L_BURST,    // Sending kernel positions
        L_GAP,      // Zero cycles between bursts
        L_DONE
    } lane_state_t;

endpackage

`default_nettype wire

//--- wl_data_pkg.sv
`default_nettype none

`include "wl_consts.svh"

package wl_data_pkg;

    // One signed weight
    typedef logic signed [`WL_WEIGHT_BITS-1:0] weight_t;

    // Input channel c sits in byte c
    typedef weight_t [`WL_VEC-1:0] weight_vec_t;

    // One ROM word, read two ways depending on the layer mode
    typedef union packed {
        weight_vec_t                  by_ch;    // Regular, four channels at one kernel column
        weight_t [`WL_KERNEL-1:0]     by_col;   // First layer, four columns of channel 0
    } rom_word_u;

    // Full tile buffer, row-major
    // Position p is row p / 4, column p % 4
    typedef weight_vec_t [`WL_KERNEL*`WL_KERNEL-1:0] kernel_t;

endpackage

`default_nettype wire

//--- wl_consts.svh
`ifndef WL_CONSTS_SVH
`define WL_CONSTS_SVH

// Kernel geometry
`define WL_KERNEL 4             // Kernel side, rows and columns
`define WL_VEC 4                // Input channels per weight vector

// Field widths
`define WL_WEIGHT_BITS 8        // One int8 weight
`define WL_WORD_BITS 32         // One ROM word
`define WL_ADDR_BITS 14         // 16K-word weight ROM
`define WL_GROUP_BITS 7         // Channel-group index and count
`define WL_OUT_CH_BITS 6        // Output-channel index

// Per-column burst schedule
`define WL_ON_CYCLES 4          // Weight cycles per burst
`define WL_GAP_CYCLES 3         // Zero cycles after each burst

`endif
